// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = lsu_store_tb
FILELIST  = lsu_store.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: lsu_store.f
rtl/lsu_pkg.sv
rtl/lsu_sq.sv
rtl/lsu_mshq.sv
rtl/lsu_dc_arb.sv
rtl/lsu_dcache.sv
rtl/lsu_store_top.sv
verif/lsu_store_tb.sv

// File: rtl/lsu_dc_arb.sv
// Cache write port arbiter; fills always win and a losing store is stalled, not queued
`timescale 1ns/100ps
`default_nettype none

module lsu_dc_arb (
    // Fill from the MSHQ
    input  wire logic                i_fill_en,
    input  wire lsu_pkg::st_write_t  i_fill,

    // Retiring store that hits in the cache
    input  wire logic                i_st_en,
    input  wire lsu_pkg::st_write_t  i_st,
    output logic                     o_st_grant,

    // The one write into the cache
    output logic                     o_wr_en,
    output lsu_pkg::st_write_t       o_wr
);

    // A fill frees an MSHQ entry and must not wait behind stores
    assign o_st_grant = !i_fill_en;

    // Either source may write, the fill taking the port when both ask
    assign o_wr_en = i_fill_en || i_st_en;

    // Store data passes only while no fill is present
    assign o_wr = i_fill_en ? i_fill : i_st;

endmodule

`default_nettype wire

// File: rtl/lsu_dcache.sv
// Direct-mapped cache with one word per line; DC_SETS a power of two, no write-back of victims
`timescale 1ns/100ps
`default_nettype none

module lsu_dcache #(
    parameter int DC_SETS = 16
) (
    input  wire logic                clk,
    input  wire logic                n_rst,

    // Hit check for the retiring store
    input  wire lsu_pkg::addr_t      i_st_addr,
    output logic                     o_st_hit,

    // Granted write from the arbiter
    input  wire logic                i_wr_en,
    input  wire lsu_pkg::st_write_t  i_wr,

    // Load lookup
    input  wire lsu_pkg::addr_t      i_ld_addr,
    output logic                     o_ld_hit,
    output lsu_pkg::data_t           o_ld_data
);

    import lsu_pkg::*;

    localparam int IDX_W = $clog2(DC_SETS);
    localparam int TAG_W = ADDR_W - IDX_W;

    // Index is the low address bits and the tag is the rest
    logic [DC_SETS-1:0] line_valid;
    logic [TAG_W-1:0]   line_tag  [DC_SETS];
    data_t              line_data [DC_SETS];

    logic [IDX_W-1:0]   st_idx;
    logic [IDX_W-1:0]   ld_idx;
    logic [IDX_W-1:0]   wr_idx;

    assign st_idx = i_st_addr[IDX_W-1:0];
    assign ld_idx = i_ld_addr[IDX_W-1:0];
    assign wr_idx = i_wr.addr[IDX_W-1:0];

    // Both lookups are purely combinational against the current line
    assign o_st_hit  = line_valid[st_idx] && (line_tag[st_idx] == i_st_addr[ADDR_W-1:IDX_W]);
    assign o_ld_hit  = line_valid[ld_idx] && (line_tag[ld_idx] == i_ld_addr[ADDR_W-1:IDX_W]);
    assign o_ld_data = line_data[ld_idx];

    // Any write makes its line valid
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            line_valid <= '0;
        end else if (i_wr_en) begin
            line_valid[wr_idx] <= 1'b1;
        end
    end

    // Stores only arrive on a hit so the old word is the one being updated
    // A fill carries a full mask and replaces the whole word
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            line_tag[wr_idx]  <= i_wr.addr[ADDR_W-1:IDX_W];
            line_data[wr_idx] <= merge_bytes(line_data[wr_idx], i_wr.data, i_wr.mask);
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_mshq.sv
// Miss holding queue; MSHQ_DEPTH of 2 or more, one memory request in flight, entries fill in age order
`timescale 1ns/100ps
`default_nettype none

module lsu_mshq #(
    parameter int MSHQ_DEPTH = 2
) (
    input  wire logic                clk,
    input  wire logic                n_rst,

    // Missed store from the store queue
    input  wire logic                i_alloc_en,
    input  wire lsu_pkg::st_write_t  i_store,
    output logic                     o_block,

    // Memory request and response
    output logic                     o_mem_req_en,
    output lsu_pkg::addr_t           o_mem_req_addr,
    input  wire logic                i_mem_resp_en,
    input  wire lsu_pkg::data_t      i_mem_resp_data,

    // Fill toward the cache write arbiter
    output logic                     o_fill_en,
    output lsu_pkg::st_write_t       o_fill
);

    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MSHQ_DEPTH);

    logic [MSHQ_DEPTH-1:0] ent_valid;
    addr_t                 ent_addr [MSHQ_DEPTH];
    data_t                 ent_data [MSHQ_DEPTH];
    mask_t                 ent_mask [MSHQ_DEPTH];

    // Entries are taken at tail and freed at head so head is always the oldest
    logic [IDX_W-1:0]      head;
    logic [IDX_W-1:0]      tail;
    fill_state_t           state;

    logic [MSHQ_DEPTH-1:0] match;
    logic                  full;
    logic                  absorb;
    logic                  merge_en;
    logic                  new_en;
    data_t                 fill_word;

    always_comb begin
        for (int i = 0; i < MSHQ_DEPTH; i++) begin
            match[i] = ent_valid[i] && (ent_addr[i] == i_store.addr);
        end
    end

    assign full    = &ent_valid;
    assign o_block = full && !(|match);

    assign o_mem_req_en   = (state == IDLE) && ent_valid[head];
    assign o_mem_req_addr = ent_addr[head];
    assign o_fill_en      = (state == WAIT_RESP) && i_mem_resp_en;

    // A store to the word being filled joins the fill instead of the freed entry
    assign absorb   = o_fill_en && i_alloc_en && match[head];
    assign merge_en = i_alloc_en && (|match) && !absorb;
    assign new_en   = i_alloc_en && !(|match) && !full;

    // Stored bytes go over the memory word and a same-cycle store goes on top
    always_comb begin
        fill_word = merge_bytes(i_mem_resp_data, ent_data[head], ent_mask[head]);
        if (absorb) begin
            fill_word = merge_bytes(fill_word, i_store.data, i_store.mask);
        end
    end

    assign o_fill.addr = ent_addr[head];
    assign o_fill.data = fill_word;
    assign o_fill.mask = '1;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
            state     <= IDLE;
        end else begin
            // Head is free once the fill leaves toward the cache
            if (o_fill_en) begin
                ent_valid[head] <= 1'b0;
                head            <= (head == IDX_W'(MSHQ_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (new_en) begin
                ent_valid[tail] <= 1'b1;
                tail            <= (tail == IDX_W'(MSHQ_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            case (state)
                IDLE:      if (o_mem_req_en) state <= WAIT_RESP;
                WAIT_RESP: if (i_mem_resp_en) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // A later store overrides the bytes it shares with an earlier one
    always_ff @(posedge clk) begin
        for (int i = 0; i < MSHQ_DEPTH; i++) begin
            if (new_en && (tail == IDX_W'(i))) begin
                ent_addr[i] <= i_store.addr;
                ent_data[i] <= i_store.data;
                ent_mask[i] <= i_store.mask;
            end else if (merge_en && match[i]) begin
                ent_data[i] <= merge_bytes(ent_data[i], i_store.data, i_store.mask);
                ent_mask[i] <= ent_mask[i] | i_store.mask;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
// Shared LSU store-side types; byte masks assume DATA_W is a whole number of bytes
`default_nettype none

package lsu_pkg;

    parameter int ADDR_W    = 32;
    parameter int DATA_W    = 32;
    parameter int ROB_TAG_W = 6;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    // Bit n of a mask enables byte n of the word
    typedef logic [DATA_W/8-1:0]   mask_t;
    typedef logic [ROB_TAG_W-1:0]  rob_tag_t;

    // Store op as allocated by the ROB, data follows later
    typedef struct packed {
        rob_tag_t rob_tag;
        addr_t    addr;
        mask_t    mask;
    } sq_alloc_t;

    // Word write toward the cache, used for retiring stores and for fills
    typedef struct packed {
        addr_t addr;
        data_t data;
        mask_t mask;
    } st_write_t;

    // Fill sequencer of the MSHQ, one memory request in flight at most
    typedef enum logic {
        IDLE,
        WAIT_RESP
    } fill_state_t;

    // Replace the bytes of old_word that are enabled in mask with those of new_word
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, mask_t mask);
        data_t r;
        r = old_word;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (mask[b]) begin
                r[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: rtl/lsu_sq.sv
// Store queue; SQ_DEPTH must be a power of two and ROB tags must be unique among valid slots
`timescale 1ns/100ps
`default_nettype none

module lsu_sq #(
    parameter int SQ_DEPTH = 8
) (
    input  wire logic                          clk,
    input  wire logic                          n_rst,
    input  wire logic                          i_flush,

    // Allocation from the ROB
    input  wire logic                          i_alloc_en,
    input  wire lsu_pkg::sq_alloc_t            i_alloc,
    output logic [$clog2(SQ_DEPTH)-1:0]        o_alloc_sq_tag,
    output logic                               o_sq_full,

    // Store data from execute
    input  wire logic                          i_data_en,
    input  wire logic [$clog2(SQ_DEPTH)-1:0]   i_data_sq_tag,
    input  wire lsu_pkg::data_t                i_data,

    // Retirement from the ROB
    input  wire logic                          i_ret_en,
    input  wire lsu_pkg::rob_tag_t             i_ret_tag,
    output logic                               o_ret_stall,
    output lsu_pkg::st_write_t                 o_ret_store,

    // Cache hit, MSHQ block and arbiter grant for the retiring store
    input  wire logic                          i_ret_hit,
    input  wire logic                          i_mshq_block,
    input  wire logic                          i_st_grant,
    output logic                               o_st_req_en,
    output logic                               o_mshq_alloc_en
);

    import lsu_pkg::*;

    localparam int SQ_TAG_W = $clog2(SQ_DEPTH);

    // Per-slot state, only the valid bits see reset
    logic [SQ_DEPTH-1:0] slot_valid;
    rob_tag_t            slot_tag  [SQ_DEPTH];
    addr_t               slot_addr [SQ_DEPTH];
    mask_t               slot_mask [SQ_DEPTH];
    data_t               slot_data [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] empty;
    logic [SQ_DEPTH-1:0] alloc_sel;
    logic [SQ_DEPTH-1:0] ret_sel;
    logic [SQ_TAG_W-1:0] ret_slot;
    logic                allocating;
    logic                retiring;

    assign empty     = ~slot_valid;
    // Isolate the lowest set bit so the lowest free slot is picked
    assign alloc_sel = empty & ~(empty - 1'b1);
    assign o_sq_full = ~|empty;

    // A new op is dropped while the queue is full
    assign allocating = i_alloc_en && !o_sq_full;

    // One valid slot at most carries the retiring ROB tag
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            ret_sel[i] = slot_valid[i] && (slot_tag[i] == i_ret_tag);
        end
    end

    // Encode both one-hot selects into slot numbers
    always_comb begin
        logic [SQ_TAG_W-1:0] a;
        logic [SQ_TAG_W-1:0] r;
        a = '0;
        r = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                a = a | SQ_TAG_W'(i);
            end
            if (ret_sel[i]) begin
                r = r | SQ_TAG_W'(i);
            end
        end
        o_alloc_sq_tag = a;
        ret_slot       = r;
    end

    assign o_ret_store.addr = slot_addr[ret_slot];
    assign o_ret_store.data = slot_data[ret_slot];
    assign o_ret_store.mask = slot_mask[ret_slot];

    // A hit waits for the write port, a miss waits while the MSHQ cannot take it
    assign o_ret_stall = i_ret_en && (i_ret_hit ? !i_st_grant : i_mshq_block);
    assign retiring    = i_ret_en && !o_ret_stall;

    // The cache write request is raised on a hit and the arbiter decides
    assign o_st_req_en     = i_ret_en && i_ret_hit;
    assign o_mshq_alloc_en = i_ret_en && !i_ret_hit && !o_ret_stall;

    // Valid bits are set on allocation and cleared by flush or retirement
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            slot_valid <= '0;
        end else if (i_flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (allocating && alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (retiring && ret_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Address, mask and tag come with allocation, data arrives by SQ tag
    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (allocating && alloc_sel[i]) begin
                slot_tag[i]  <= i_alloc.rob_tag;
                slot_addr[i] <= i_alloc.addr;
                slot_mask[i] <= i_alloc.mask;
            end
            if (i_data_en && (i_data_sq_tag == SQ_TAG_W'(i))) begin
                slot_data[i] <= i_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_store_top.sv
// Store side of the LSU; one memory request at a time and no store-to-load forwarding
`timescale 1ns/100ps
`default_nettype none

module lsu_store_top #(
    parameter int SQ_DEPTH   = 8,
    parameter int MSHQ_DEPTH = 2,
    parameter int DC_SETS    = 16
) (
    input  wire logic                          clk,
    input  wire logic                          n_rst,
    input  wire logic                          i_flush,
    input  wire logic                          i_alloc_en,
    input  wire lsu_pkg::sq_alloc_t            i_alloc,
    output logic [$clog2(SQ_DEPTH)-1:0]        o_alloc_sq_tag,
    output logic                               o_sq_full,
    input  wire logic                          i_data_en,
    input  wire logic [$clog2(SQ_DEPTH)-1:0]   i_data_sq_tag,
    input  wire lsu_pkg::data_t                i_data,
    input  wire logic                          i_ret_en,
    input  wire lsu_pkg::rob_tag_t             i_ret_tag,
    output logic                               o_ret_stall,
    output logic                               o_mem_req_en,
    output lsu_pkg::addr_t                     o_mem_req_addr,
    input  wire logic                          i_mem_resp_en,
    input  wire lsu_pkg::data_t                i_mem_resp_data,
    input  wire lsu_pkg::addr_t                i_ld_addr,
    output logic                               o_ld_hit,
    output lsu_pkg::data_t                     o_ld_data
);

    import lsu_pkg::*;

    // Retiring store and its routing
    st_write_t ret_store;
    logic      ret_hit;
    logic      mshq_block;
    logic      st_grant;
    logic      st_req_en;
    logic      mshq_alloc_en;

    // Fill and granted cache write
    logic      fill_en;
    st_write_t fill;
    logic      wr_en;
    st_write_t wr;

    lsu_sq #(
        .SQ_DEPTH (SQ_DEPTH)
    ) lsu_sq_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_flush         (i_flush),
        .i_alloc_en      (i_alloc_en),
        .i_alloc         (i_alloc),
        .o_alloc_sq_tag  (o_alloc_sq_tag),
        .o_sq_full       (o_sq_full),
        .i_data_en       (i_data_en),
        .i_data_sq_tag   (i_data_sq_tag),
        .i_data          (i_data),
        .i_ret_en        (i_ret_en),
        .i_ret_tag       (i_ret_tag),
        .o_ret_stall     (o_ret_stall),
        .o_ret_store     (ret_store),
        .i_ret_hit       (ret_hit),
        .i_mshq_block    (mshq_block),
        .i_st_grant      (st_grant),
        .o_st_req_en     (st_req_en),
        .o_mshq_alloc_en (mshq_alloc_en)
    );

    lsu_mshq #(
        .MSHQ_DEPTH (MSHQ_DEPTH)
    ) lsu_mshq_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_alloc_en      (mshq_alloc_en),
        .i_store         (ret_store),
        .o_block         (mshq_block),
        .o_mem_req_en    (o_mem_req_en),
        .o_mem_req_addr  (o_mem_req_addr),
        .i_mem_resp_en   (i_mem_resp_en),
        .i_mem_resp_data (i_mem_resp_data),
        .o_fill_en       (fill_en),
        .o_fill          (fill)
    );

    lsu_dc_arb lsu_dc_arb_inst (
        .i_fill_en  (fill_en),
        .i_fill     (fill),
        .i_st_en    (st_req_en),
        .i_st       (ret_store),
        .o_st_grant (st_grant),
        .o_wr_en    (wr_en),
        .o_wr       (wr)
    );

    lsu_dcache #(
        .DC_SETS (DC_SETS)
    ) lsu_dcache_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_st_addr (ret_store.addr),
        .o_st_hit  (ret_hit),
        .i_wr_en   (wr_en),
        .i_wr      (wr),
        .i_ld_addr (i_ld_addr),
        .o_ld_hit  (o_ld_hit),
        .o_ld_data (o_ld_data)
    );

endmodule

`default_nettype wire

// File: verif/lsu_store_tb.sv
// Store-side LSU testbench; test addresses never share a cache set, and build with assertions on
`timescale 1ns/100ps
`default_nettype none

module lsu_store_tb;

    import lsu_pkg::*;

    localparam int SQ_DEPTH   = 8;
    localparam int MSHQ_DEPTH = 2;
    localparam int DC_SETS    = 16;
    localparam int SQ_TAG_W   = $clog2(SQ_DEPTH);
    // All tests together take a few hundred cycles, responses included
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clk;
    logic                n_rst;
    logic                i_flush;
    logic                i_alloc_en;
    sq_alloc_t           i_alloc;
    logic [SQ_TAG_W-1:0] o_alloc_sq_tag;
    logic                o_sq_full;
    logic                i_data_en;
    logic [SQ_TAG_W-1:0] i_data_sq_tag;
    data_t               i_data;
    logic                i_ret_en;
    rob_tag_t            i_ret_tag;
    logic                o_ret_stall;
    logic                o_mem_req_en;
    addr_t               o_mem_req_addr;
    logic                i_mem_resp_en;
    data_t               i_mem_resp_data;
    addr_t               i_ld_addr;
    logic                o_ld_hit;
    data_t               o_ld_data;

    integer seed = 32'h8005_4c16;
    int     err_count = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     test_err_base;
    string  test_name;
    int     cycle_count = 0;

    // Memory image, one random word per address, made on first request
    data_t  mem_image [addr_t];
    addr_t  req_log [$];
    int     resp_count = 0;
    logic   resp_hold = 1'b0;

    // Reference store bytes per address, accumulated in retire order
    data_t  ref_data [addr_t];
    mask_t  ref_mask [addr_t];

    // What each ROB tag was allocated with
    addr_t  st_addr [64];
    data_t  st_data [64];
    mask_t  st_mask [64];

    lsu_store_top #(
        .SQ_DEPTH   (SQ_DEPTH),
        .MSHQ_DEPTH (MSHQ_DEPTH),
        .DC_SETS    (DC_SETS)
    ) lsu_store_top_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_flush         (i_flush),
        .i_alloc_en      (i_alloc_en),
        .i_alloc         (i_alloc),
        .o_alloc_sq_tag  (o_alloc_sq_tag),
        .o_sq_full       (o_sq_full),
        .i_data_en       (i_data_en),
        .i_data_sq_tag   (i_data_sq_tag),
        .i_data          (i_data),
        .i_ret_en        (i_ret_en),
        .i_ret_tag       (i_ret_tag),
        .o_ret_stall     (o_ret_stall),
        .o_mem_req_en    (o_mem_req_en),
        .o_mem_req_addr  (o_mem_req_addr),
        .i_mem_resp_en   (i_mem_resp_en),
        .i_mem_resp_data (i_mem_resp_data),
        .i_ld_addr       (i_ld_addr),
        .o_ld_hit        (o_ld_hit),
        .o_ld_data       (o_ld_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // A request is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!n_rst) o_mem_req_en |=> !o_mem_req_en)
    else begin
        $display("Memory request stayed high for two cycles in %s", test_name);
        err_count++;
    end

    // Only one request may be outstanding, so none is raised while a response lands
    assert property (@(posedge clk) disable iff (!n_rst) i_mem_resp_en |-> !o_mem_req_en)
    else begin
        $display("Memory request raised during a response in %s", test_name);
        err_count++;
    end

    // Memory answers each request after 1 to 6 cycles unless responses are withheld
    initial begin
        int unsigned delay;
        addr_t       a;
        i_mem_resp_en   = 1'b0;
        i_mem_resp_data = '0;
        forever begin
            @(negedge clk);
            if (n_rst && o_mem_req_en) begin
                a = o_mem_req_addr;
                req_log.push_back(a);
                if (!mem_image.exists(a)) begin
                    mem_image[a] = $random(seed);
                end
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                while (resp_hold) begin
                    @(posedge clk);
                end
                i_mem_resp_en   <= 1'b1;
                i_mem_resp_data <= mem_image[a];
                @(posedge clk);
                i_mem_resp_en <= 1'b0;
                resp_count++;
            end
        end
    end

    function automatic data_t apply_mask(data_t old_word, data_t new_word, mask_t mask);
        data_t bits;
        bits = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_word & ~bits) | (new_word & bits);
    endfunction

    // Memory word with every retired store to it laid on top
    function automatic data_t expected_word(addr_t a);
        return apply_mask(mem_image[a], ref_data[a], ref_mask[a]);
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else begin
            $display("FAIL %s (%s): expected %0h, actual %0h", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = err_count;
    endtask

    task automatic finish_test();
        if (err_count == test_err_base) begin
            $display("test %s passed", test_name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", test_name, err_count - test_err_base);
            tests_failed++;
        end
    endtask

    // Allocate a store and send its data one cycle later
    task automatic issue_store(input rob_tag_t rob, input addr_t a, input mask_t m,
                               output logic [SQ_TAG_W-1:0] tag, output logic full_before);
        data_t d;
        d = $random(seed);
        @(posedge clk);
        i_alloc_en <= 1'b1;
        i_alloc    <= '{rob_tag: rob, addr: a, mask: m};
        @(negedge clk);
        tag         = o_alloc_sq_tag;
        full_before = o_sq_full;
        @(posedge clk);
        i_alloc_en    <= 1'b0;
        i_data_en     <= 1'b1;
        i_data_sq_tag <= tag;
        i_data        <= d;
        @(posedge clk);
        i_data_en <= 1'b0;
        st_addr[rob] = a;
        st_data[rob] = d;
        st_mask[rob] = m;
    endtask

    // Hold the retire request until the stall drops, counting stalled cycles
    task automatic retire_store(input rob_tag_t rob, output int stalls);
        addr_t a;
        stalls = 0;
        @(posedge clk);
        i_ret_en  <= 1'b1;
        i_ret_tag <= rob;
        @(negedge clk);
        while (o_ret_stall) begin
            stalls++;
            @(negedge clk);
        end
        // Taken at the coming edge so the reference sees retire order
        a = st_addr[rob];
        if (!ref_mask.exists(a)) begin
            ref_data[a] = '0;
            ref_mask[a] = '0;
        end
        ref_data[a] = apply_mask(ref_data[a], st_data[rob], st_mask[rob]);
        ref_mask[a] = ref_mask[a] | st_mask[rob];
        @(posedge clk);
        i_ret_en <= 1'b0;
    endtask

    task automatic check_load(input string what, input addr_t a, input logic exp_hit);
        @(posedge clk);
        i_ld_addr <= a;
        @(negedge clk);
        check_value({what, " hit"}, exp_hit, o_ld_hit);
        if (exp_hit) begin
            check_value({what, " data"}, expected_word(a), o_ld_data);
        end
    endtask

    // Wait for a response count, then one edge more so the fill is in the cache
    task automatic wait_responses(input int target);
        while (resp_count < target) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic set_hold(input logic hold);
        @(negedge clk);
        resp_hold = hold;
    endtask

    initial begin
        logic [SQ_TAG_W-1:0] tag;
        logic                full_before;
        int                  stalls;
        int                  req_base;
        int                  resp_base;
        // One cache set per test address
        addr_t               a_miss;
        addr_t               b_merge;
        addr_t               c_addr [3];
        addr_t               d_fill;

        a_miss    = 32'h0000_4a01;
        b_merge   = 32'h0000_7c02;
        d_fill    = 32'h0002_3007;
        c_addr[0] = 32'h0001_0004;
        c_addr[1] = 32'h0001_1005;
        c_addr[2] = 32'h0001_2006;
        n_rst         = 1'b0;
        i_flush       = 1'b0;
        i_alloc_en    = 1'b0;
        i_alloc       = '0;
        i_data_en     = 1'b0;
        i_data_sq_tag = '0;
        i_data        = '0;
        i_ret_en      = 1'b0;
        i_ret_tag     = '0;
        i_ld_addr     = '0;
        repeat (3) @(posedge clk);
        n_rst <= 1'b1;

        start_test("reset");
        @(negedge clk);
        check_value("sq_full", 1'b0, o_sq_full);
        check_value("ret_stall", 1'b0, o_ret_stall);
        check_value("mem_req_en", 1'b0, o_mem_req_en);
        for (int s = 0; s < DC_SETS; s++) begin
            check_load("cold line", 32'h0000_5a00 + addr_t'(s), 1'b0);
        end
        finish_test();

        start_test("allocation");
        for (int i = 0; i < SQ_DEPTH; i++) begin
            // Slot 3 holds a partial store to a cold word for the miss path test
            if (i == 3) begin
                issue_store(rob_tag_t'(i), a_miss, 4'b0101, tag, full_before);
            end else begin
                issue_store(rob_tag_t'(i), 32'h0003_0000 + addr_t'(i), 4'b1111, tag,
                            full_before);
            end
            check_value("alloc tag", i, tag);
            check_value("full before alloc", 1'b0, full_before);
        end
        @(negedge clk);
        check_value("full after eighth", 1'b1, o_sq_full);
        req_base   = req_log.size();
        retire_store(6'd3, stalls);
        check_value("retire stall", 0, stalls);
        issue_store(6'd8, 32'h0003_0100, 4'b1111, tag, full_before);
        check_value("realloc tag", 3, tag);
        check_value("full before realloc", 1'b0, full_before);
        finish_test();

        start_test("miss_path");
        wait_responses(1);
        repeat (3) @(posedge clk);
        check_value("request count", 1, req_log.size() - req_base);
        check_value("request addr", a_miss, req_log[req_base]);
        check_load("merged word", a_miss, 1'b1);
        finish_test();

        start_test("flush");
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        @(negedge clk);
        check_value("sq_full", 1'b0, o_sq_full);
        issue_store(6'd9, 32'h0003_0200, 4'b1111, tag, full_before);
        check_value("first tag", 0, tag);
        check_load("retired word", a_miss, 1'b1);
        finish_test();

        start_test("merge");
        set_hold(1'b1);
        issue_store(6'd10, b_merge, 4'b0011, tag, full_before);
        issue_store(6'd11, b_merge, 4'b0110, tag, full_before);
        req_base  = req_log.size();
        resp_base = resp_count;
        retire_store(6'd10, stalls);
        retire_store(6'd11, stalls);
        repeat (8) @(posedge clk);
        set_hold(1'b0);
        wait_responses(resp_base + 1);
        repeat (3) @(posedge clk);
        check_value("request count", 1, req_log.size() - req_base);
        check_value("request addr", b_merge, req_log[req_base]);
        check_load("merged word", b_merge, 1'b1);
        finish_test();

        start_test("hit_store");
        issue_store(6'd12, a_miss, 4'b1000, tag, full_before);
        retire_store(6'd12, stalls);
        check_value("hit stall", 0, stalls);
        check_load("partial update", a_miss, 1'b1);
        finish_test();

        start_test("miss_stall");
        for (int i = 0; i < 3; i++) begin
            issue_store(rob_tag_t'(13 + i), c_addr[i], 4'b1111, tag, full_before);
        end
        set_hold(1'b1);
        resp_base = resp_count;
        retire_store(6'd13, stalls);
        check_value("first miss stall", 0, stalls);
        retire_store(6'd14, stalls);
        check_value("second miss stall", 0, stalls);
        // The third miss finds both entries busy until a response frees one
        fork
            retire_store(6'd15, stalls);
            begin
                repeat (4) @(negedge clk);
                resp_hold = 1'b0;
            end
        join
        assert (stalls >= 3)
        else begin
            $display("Third miss in %s did not stall while responses were held", test_name);
            err_count++;
        end
        check_value("response freed entry", 1'b1, resp_count > resp_base);
        wait_responses(resp_base + 3);
        for (int i = 0; i < 3; i++) begin
            check_load("filled word", c_addr[i], 1'b1);
        end
        finish_test();

        start_test("fill_collision");
        set_hold(1'b1);
        resp_base = resp_count;
        issue_store(6'd16, d_fill, 4'b1100, tag, full_before);
        retire_store(6'd16, stalls);
        issue_store(6'd17, a_miss, 4'b0010, tag, full_before);
        repeat (8) @(posedge clk);
        // Release lands the response on the same cycle the hit store retires
        set_hold(1'b0);
        retire_store(6'd17, stalls);
        check_value("hit stall in fill cycle", 1, stalls);
        wait_responses(resp_base + 1);
        check_load("hit word", a_miss, 1'b1);
        check_load("filled word", d_fill, 1'b1);
        finish_test();

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
